// File: Makefile
# Verilator build and run of the glay_kernel testbench

VERILATOR ?= verilator
TOP       ?= tb_glay_kernel
FILELIST  ?= glay_kernel.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then exit 1; fi
	@grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: glay_kernel.f
verilog/glay_pkg.sv
verilog/kernel_control.sv
verilog/mem_arbiter.sv
verilog/scratch_memory.sv
verilog/array_read_engine.sv
verilog/array_write_engine.sv
verilog/glay_kernel_top.sv
tests/tb_glay_kernel.sv

// File: tests/tb_glay_kernel.sv
`timescale 1ns/1ps

module tb_glay_kernel import glay_pkg::*; ();

    // Wait limits in clock cycles
    localparam int GRANT_LIMIT     = 64;
    localparam int RVALID_LIMIT    = 8;
    localparam int HANDSHAKE_LIMIT = 2000;

    logic                     ap_clk;
    logic                     areset_control;
    logic                     ap_start;
    kernel_descriptor_payload descriptor_in;
    logic                     ap_ready;
    logic                     ap_done;
    logic                     ap_idle;
    mem_request               host_req;
    logic                     host_grant;
    logic [31:0]              host_rdata;
    logic                     host_rvalid;

    // Expected scratch memory contents
    logic [31:0] shadow [MEM_DEPTH];
    string       test_name;

    glay_kernel_top dut0 (
        .ap_clk         (ap_clk),
        .areset_control (areset_control),
        .ap_start       (ap_start),
        .descriptor_in  (descriptor_in),
        .ap_ready       (ap_ready),
        .ap_done        (ap_done),
        .ap_idle        (ap_idle),
        .host_req       (host_req),
        .host_grant     (host_grant),
        .host_rdata     (host_rdata),
        .host_rvalid    (host_rvalid)
    );

    initial begin
        ap_clk = 1'b0;
        forever #10 ap_clk = ~ap_clk;
    end

    // --------------------------------------------------
    // Reporting and checks
    // --------------------------------------------------
    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_word(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual === expected) else begin
            stop_on_error($sformatf("Mismatch in %s, %s: expected %08h, actual %08h",
                                    test_name, what, expected, actual));
        end
    endtask

    // Byte order reversal, lowest byte moves to the top
    function automatic logic [31:0] reverse_bytes(input logic [31:0] w);
        logic [31:0] r;
        int          b;
        for (b = 0; b < 4; b++) begin
            r[8*b +: 8] = w[8*(3-b) +: 8];
        end
        return r;
    endfunction

    // --------------------------------------------------
    // Host port
    // --------------------------------------------------
    task automatic issue_host_request(input mem_request req);
        int   cycles;
        logic granted;
        granted = 1'b0;
        @(posedge ap_clk);
        host_req <= req;
        // Held until the arbiter picks the host
        for (cycles = 0; cycles < GRANT_LIMIT && !granted; cycles++) begin
            @(negedge ap_clk);
            granted = host_grant;
        end
        assert (granted) else begin
            stop_on_error($sformatf("%s: host request was never granted", test_name));
        end
        // Consumed at this edge
        @(posedge ap_clk);
        host_req <= '0;
    endtask

    task automatic host_write(input int addr, input logic [31:0] data);
        mem_request req;
        req.valid = 1'b1;
        req.write = 1'b1;
        req.addr  = addr[MEM_ADDR_W-1:0];
        req.data  = data;
        issue_host_request(req);
        shadow[addr] = data;
    endtask

    task automatic host_read(input int addr, output logic [31:0] data);
        mem_request req;
        int         cycles;
        logic       seen;
        req.valid = 1'b1;
        req.write = 1'b0;
        req.addr  = addr[MEM_ADDR_W-1:0];
        req.data  = '0;
        seen      = 1'b0;
        issue_host_request(req);
        for (cycles = 0; cycles < RVALID_LIMIT && !seen; cycles++) begin
            @(negedge ap_clk);
            seen = host_rvalid;
        end
        assert (seen) else begin
            stop_on_error($sformatf("%s: no read data returned for address %0d",
                                    test_name, addr));
        end
        data = host_rdata;
    endtask

    // Full read-back against the shadow copy
    task automatic compare_memory();
        int          a;
        logic [31:0] rd;
        for (a = 0; a < MEM_DEPTH; a++) begin
            host_read(a, rd);
            check_word($sformatf("word %0d", a), shadow[a], rd);
        end
    endtask

    // --------------------------------------------------
    // Kernel control
    // --------------------------------------------------
    task automatic wait_handshake(input bit want_done, input string what);
        int   cycles;
        logic seen;
        seen = 1'b0;
        for (cycles = 0; cycles < HANDSHAKE_LIMIT && !seen; cycles++) begin
            @(negedge ap_clk);
            seen = want_done ? ap_done : ap_ready;
        end
        assert (seen) else begin
            stop_on_error($sformatf("%s: %s never went high", test_name, what));
        end
    endtask

    // Source in one half, destination in the other
    task automatic pick_buffers(input int len, output int src, output int dst);
        int lo;
        int hi;
        lo = int'($urandom % (128 - len));
        hi = 128 + int'($urandom % (128 - len));
        if ($urandom % 2 == 0) begin
            src = lo;
            dst = hi;
        end else begin
            src = hi;
            dst = lo;
        end
    endtask

    task automatic run_transfer(input int src, input int dst, input int len,
                                input logic [1:0] flags);
        kernel_descriptor_payload desc;
        logic [31:0]              expected [$];
        logic [31:0]              w;
        int                       i;
        desc.buffer_0 = src;
        desc.buffer_1 = dst;
        desc.buffer_2 = len;
        desc.buffer_9 = {30'd0, flags};
        // Model of the two swaps
        for (i = 0; i < len; i++) begin
            w = shadow[src + i];
            if (flags[0]) w = reverse_bytes(w);
            if (flags[1]) w = reverse_bytes(w);
            expected.push_back(w);
        end
        @(posedge ap_clk);
        descriptor_in <= desc;
        ap_start      <= 1'b1;
        wait_handshake(1'b0, "ap_ready");
        @(posedge ap_clk);
        ap_start <= 1'b0;
        wait_handshake(1'b1, "ap_done");
        for (i = 0; i < len; i++) begin
            shadow[dst + i] = expected[i];
        end
        compare_memory();
    endtask

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        int          a;
        int          k;
        int          f;
        int          src;
        int          dst;
        int          len;
        logic [31:0] rd;
        logic [31:0] source_copy [$];

        areset_control = 1'b1;
        ap_start       = 1'b0;
        descriptor_in  = '0;
        host_req       = '0;
        test_name      = "reset";
        void'($urandom(32'hdf20));

        repeat (3) @(posedge ap_clk);
        areset_control <= 1'b0;
        @(negedge ap_clk);
        check_word("ap_idle", 32'd1, 32'(ap_idle));
        check_word("ap_ready", 32'd0, 32'(ap_ready));
        check_word("ap_done", 32'd0, 32'(ap_done));
        check_word("host_grant", 32'd0, 32'(host_grant));

        // Random fill, then random writes and reads
        test_name = "host_access";
        for (a = 0; a < MEM_DEPTH; a++) begin
            host_write(a, $urandom);
        end
        for (k = 0; k < 24; k++) begin
            host_write(int'($urandom % MEM_DEPTH), $urandom);
        end
        for (k = 0; k < 24; k++) begin
            a = int'($urandom % MEM_DEPTH);
            host_read(a, rd);
            check_word($sformatf("address %0d", a), shadow[a], rd);
        end

        test_name = "plain_copy";
        len = 1 + int'($urandom % 32);
        pick_buffers(len, src, dst);
        run_transfer(src, dst, len, 2'b00);

        // Each swap combination on its own
        for (f = 0; f < 4; f++) begin
            test_name = $sformatf("endian_flags_%0d", f);
            len = 1 + int'($urandom % 32);
            pick_buffers(len, src, dst);
            run_transfer(src, dst, len, f[1:0]);
        end

        test_name = "restart_from_done";
        len = 1 + int'($urandom % 32);
        pick_buffers(len, src, dst);
        source_copy.delete();
        for (k = 0; k < len; k++) begin
            source_copy.push_back(shadow[src + k]);
        end
        run_transfer(src, dst, len, 2'b01);
        for (k = 0; k < len; k++) begin
            host_read(src + k, rd);
            check_word($sformatf("source word %0d", k), source_copy[k], rd);
        end

        // Nothing may move
        test_name = "zero_length";
        pick_buffers(0, src, dst);
        run_transfer(src, dst, 0, 2'b11);

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: verilog/array_read_engine.sv
`timescale 1ns/1ps

module array_read_engine import glay_pkg::*; (
    input  logic             ap_clk,
    input  logic             areset_control,
    input  kernel_descriptor descriptor,
    input  logic             run,
    input  logic             endian_read,
    output mem_request       mem_req,
    input  logic             grant,
    input  logic             rvalid,
    input  logic [31:0]      rdata,
    output logic [31:0]      word,
    output logic             word_valid,
    input  logic             word_taken,
    output logic             idle
);

    logic        started;
    logic [31:0] rd_index;
    logic [31:0] src_addr;
    logic        pending;
    logic [31:0] spare;
    logic        spare_valid;
    logic [31:0] fetched;
    logic [1:0]  occupancy;
    logic        issue;
    logic        to_word;

    // --------------------------------------------------
    // Read issue
    // --------------------------------------------------
    assign src_addr  = descriptor.payload.buffer_0 + rd_index;
    // Held, landed and in flight words together
    assign occupancy = {1'b0, word_valid} + {1'b0, spare_valid} + {1'b0, pending};
    assign issue     = started && (rd_index != descriptor.payload.buffer_2)
                     && (occupancy < 2'd2);

    assign mem_req.valid = issue;
    assign mem_req.write = 1'b0;
    assign mem_req.addr  = src_addr[MEM_ADDR_W-1:0];
    assign mem_req.data  = '0;

    // Swap on arrival
    assign fetched = endian_read ? byte_swap(rdata) : rdata;
    // Returned data fills the held slot when it frees up
    assign to_word = rvalid && (!word_valid || word_taken);

    assign idle = !started || ((rd_index == descriptor.payload.buffer_2) && !pending
                  && !word_valid && !spare_valid);

    always_ff @(posedge ap_clk) begin
        if (areset_control) begin
            started     <= 1'b0;
            rd_index    <= '0;
            pending     <= 1'b0;
            word_valid  <= 1'b0;
            spare_valid <= 1'b0;
        end else begin
            // One pass per valid descriptor
            if (run && !started) begin
                started  <= 1'b1;
                rd_index <= '0;
            end else if (!descriptor.valid) begin
                started <= 1'b0;
            end
            if (issue && grant) rd_index <= rd_index + 32'd1;
            if (issue && grant) begin
                pending <= 1'b1;
            end else if (rvalid) begin
                pending <= 1'b0;
            end
            if (to_word) begin
                word_valid <= 1'b1;
            end else if (word_taken) begin
                word_valid <= spare_valid;
            end
            if (rvalid && !to_word) begin
                spare_valid <= 1'b1;
            end else if (word_taken) begin
                spare_valid <= 1'b0;
            end
        end
    end

    // Data slots
    always_ff @(posedge ap_clk) begin
        if (to_word) begin
            word <= fetched;
        end else if (word_taken) begin
            word <= spare;
        end
        if (rvalid && !to_word) spare <= fetched;
    end

    rvalid_has_read: assert property (@(posedge ap_clk) disable iff (areset_control)
        rvalid |-> pending)
        else $error("read data without an outstanding read");

endmodule

// File: verilog/array_write_engine.sv
`timescale 1ns/1ps

module array_write_engine import glay_pkg::*; (
    input  logic             ap_clk,
    input  logic             areset_control,
    input  kernel_descriptor descriptor,
    input  logic             run,
    input  logic             endian_write,
    input  logic [31:0]      word,
    input  logic             word_valid,
    output logic             word_taken,
    output mem_request       mem_req,
    input  logic             grant,
    output logic             done
);

    logic        started;
    logic [31:0] wr_index;
    logic [31:0] dst_addr;
    logic        remaining;

    // --------------------------------------------------
    // Write request
    // --------------------------------------------------
    assign dst_addr  = descriptor.payload.buffer_1 + wr_index;
    assign remaining = started && (wr_index != descriptor.payload.buffer_2);

    assign mem_req.valid = remaining && word_valid;
    assign mem_req.write = 1'b1;
    assign mem_req.addr  = dst_addr[MEM_ADDR_W-1:0];
    assign mem_req.data  = endian_write ? byte_swap(word) : word;

    // Word leaves the reader on the granted cycle
    assign word_taken = mem_req.valid && grant;

    // Zero count finishes as soon as the pass starts
    assign done = started && !remaining;

    always_ff @(posedge ap_clk) begin
        if (areset_control) begin
            started  <= 1'b0;
            wr_index <= '0;
        end else begin
            if (run && !started) begin
                started  <= 1'b1;
                wr_index <= '0;
            end else if (!descriptor.valid) begin
                // Drops done once the descriptor retires
                started <= 1'b0;
            end
            if (word_taken) wr_index <= wr_index + 32'd1;
        end
    end

endmodule

// File: verilog/glay_kernel_top.sv
`timescale 1ns/1ps

module glay_kernel_top import glay_pkg::*; (
    input  logic                     ap_clk,
    input  logic                     areset_control,
    input  logic                     ap_start,
    input  kernel_descriptor_payload descriptor_in,
    output logic                     ap_ready,
    output logic                     ap_done,
    output logic                     ap_idle,
    input  mem_request               host_req,
    output logic                     host_grant,
    output logic [31:0]              host_rdata,
    output logic                     host_rvalid
);

    control_chain_in      control_in;
    control_chain_out     control_out;
    kernel_descriptor     descriptor;
    mem_request           peer_req [NUM_PEERS];
    mem_request           mem_req;
    logic [NUM_PEERS-1:0] grant;
    logic [NUM_PEERS-1:0] rvalid;
    logic [31:0]          rdata;
    logic                 run;
    logic [31:0]          word;
    logic                 word_valid;
    logic                 word_taken;
    logic                 reader_idle;
    logic                 writer_done;

    // --------------------------------------------------
    // Control path
    // --------------------------------------------------
    assign control_in.ap_start = ap_start;
    assign control_in.setup    = reader_idle;
    assign control_in.done     = writer_done;

    // Engines move only under a live descriptor
    assign run = descriptor.valid && control_out.start;

    assign ap_ready = control_out.ap_ready;
    assign ap_done  = control_out.ap_done;
    assign ap_idle  = control_out.ap_idle;

    kernel_control control0 (
        .ap_clk         (ap_clk),
        .areset_control (areset_control),
        .control_in     (control_in),
        .control_out    (control_out),
        .descriptor_in  (descriptor_in),
        .descriptor_out (descriptor)
    );

    // --------------------------------------------------
    // Memory path
    // --------------------------------------------------
    assign peer_req[PEER_HOST] = host_req;
    assign host_grant  = grant[PEER_HOST];
    assign host_rvalid = rvalid[PEER_HOST];
    assign host_rdata  = rdata;

    mem_arbiter arb0 (
        .ap_clk         (ap_clk),
        .areset_control (areset_control),
        .req            (peer_req),
        .grant          (grant),
        .rvalid         (rvalid),
        .mem_req        (mem_req)
    );

    scratch_memory mem0 (
        .ap_clk  (ap_clk),
        .mem_req (mem_req),
        .rdata   (rdata)
    );

    // Read side
    array_read_engine reader0 (
        .ap_clk         (ap_clk),
        .areset_control (areset_control),
        .descriptor     (descriptor),
        .run            (run),
        .endian_read    (control_out.endian_read),
        .mem_req        (peer_req[PEER_READ]),
        .grant          (grant[PEER_READ]),
        .rvalid         (rvalid[PEER_READ]),
        .rdata          (rdata),
        .word           (word),
        .word_valid     (word_valid),
        .word_taken     (word_taken),
        .idle           (reader_idle)
    );

    // Write side
    array_write_engine writer0 (
        .ap_clk         (ap_clk),
        .areset_control (areset_control),
        .descriptor     (descriptor),
        .run            (run),
        .endian_write   (control_out.endian_write),
        .word           (word),
        .word_valid     (word_valid),
        .word_taken     (word_taken),
        .mem_req        (peer_req[PEER_WRITE]),
        .grant          (grant[PEER_WRITE]),
        .done           (writer_done)
    );

endmodule

// File: verilog/glay_pkg.sv
package glay_pkg;

    // --------------------------------------------------
    // Scratch memory geometry
    // --------------------------------------------------
    localparam int MEM_DEPTH  = 256;
    localparam int MEM_ADDR_W = $clog2(MEM_DEPTH);

    // Arbiter peers, host first
    localparam int NUM_PEERS  = 3;
    localparam int PEER_IDX_W = $clog2(NUM_PEERS);
    localparam int PEER_HOST  = 0;
    localparam int PEER_READ  = 1;
    localparam int PEER_WRITE = 2;

    // --------------------------------------------------
    // Descriptor and control chain
    // --------------------------------------------------
    typedef struct packed {
        logic [31:0] buffer_0;   // Source base
        logic [31:0] buffer_1;   // Destination base
        logic [31:0] buffer_2;   // Word count
        logic [31:0] buffer_9;   // Bit 0 read swap, bit 1 write swap
    } kernel_descriptor_payload;

    typedef struct packed {
        logic                     valid;
        kernel_descriptor_payload payload;
    } kernel_descriptor;

    typedef struct packed {
        logic ap_start;
        logic setup;
        logic done;
    } control_chain_in;

    typedef struct packed {
        logic ap_ready;
        logic ap_done;
        logic ap_idle;
        logic start;
        logic endian_read;
        logic endian_write;
    } control_chain_out;

    // Quiet control outputs, idle raised
    localparam control_chain_out CONTROL_OUT_IDLE = '{
        ap_ready     : 1'b0,
        ap_done      : 1'b0,
        ap_idle      : 1'b1,
        start        : 1'b0,
        endian_read  : 1'b0,
        endian_write : 1'b0
    };

    // One request into the shared memory
    typedef struct packed {
        logic                  valid;
        logic                  write;
        logic [MEM_ADDR_W-1:0] addr;
        logic [31:0]           data;
    } mem_request;

    typedef enum logic [2:0] {
        RESET,
        IDLE,
        SETUP,
        READY,
        START,
        BUSY,
        DONE
    } control_sync_state;

    // Byte order reversal of one word
    function automatic logic [31:0] byte_swap(input logic [31:0] w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

endpackage

// File: verilog/kernel_control.sv
`timescale 1ns/1ps

module kernel_control import glay_pkg::*; (
    input  logic                     ap_clk,
    input  logic                     areset_control,
    input  control_chain_in          control_in,
    output control_chain_out         control_out,
    input  kernel_descriptor_payload descriptor_in,
    output kernel_descriptor         descriptor_out
);

    // Registered inputs
    logic ap_start_reg;
    logic setup_reg;
    logic done_reg;
    kernel_descriptor_payload descriptor_in_reg;

    control_sync_state current_state;
    control_sync_state next_state;

    // Decoded outputs and their two pipeline stages
    control_chain_out ctrl_dec;
    control_chain_out ctrl_s1;
    control_chain_out ctrl_s2;
    logic valid_dec;
    logic valid_s1;
    logic valid_s2;

    // --------------------------------------------------
    // Input registers
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_control) begin
            ap_start_reg <= 1'b0;
            setup_reg    <= 1'b1;
            done_reg     <= 1'b0;
        end else begin
            ap_start_reg <= control_in.ap_start;
            setup_reg    <= control_in.setup;
            done_reg     <= control_in.done;
        end
    end

    // --------------------------------------------------
    // User managed sync FSM
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_control) begin
            current_state <= RESET;
        end else begin
            current_state <= next_state;
        end
    end

    always_comb begin
        next_state = current_state;
        case (current_state)
            RESET: next_state = IDLE;
            IDLE:  next_state = SETUP;
            // Wait for the host
            SETUP: if (ap_start_reg) next_state = READY;
            // Wait for the read engine to be idle
            READY: if (setup_reg) next_state = START;
            START: next_state = BUSY;
            BUSY:  if (done_reg) next_state = DONE;
            // Restart on a fresh ap_start
            DONE:  if (ap_start_reg) next_state = READY;
            default: next_state = RESET;
        endcase
    end

    // Output decode
    always_comb begin
        ctrl_dec  = CONTROL_OUT_IDLE;
        valid_dec = 1'b0;
        case (current_state)
            SETUP: ctrl_dec.start = 1'b1;
            READY: begin
                ctrl_dec.ap_ready = 1'b1;
                ctrl_dec.ap_idle  = 1'b0;
                ctrl_dec.start    = 1'b1;
            end
            START, BUSY: begin
                ctrl_dec.ap_idle      = 1'b0;
                ctrl_dec.start        = 1'b1;
                ctrl_dec.endian_read  = descriptor_in_reg.buffer_9[0];
                ctrl_dec.endian_write = descriptor_in_reg.buffer_9[1];
                valid_dec             = 1'b1;
            end
            DONE: ctrl_dec.ap_done = 1'b1;
            default: ;
        endcase
    end

    // --------------------------------------------------
    // Output pipeline
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        // Payload two cycles behind the input
        descriptor_in_reg      <= descriptor_in;
        descriptor_out.payload <= descriptor_in_reg;
        if (areset_control) begin
            ctrl_s1              <= CONTROL_OUT_IDLE;
            ctrl_s2              <= CONTROL_OUT_IDLE;
            control_out          <= CONTROL_OUT_IDLE;
            valid_s1             <= 1'b0;
            valid_s2             <= 1'b0;
            descriptor_out.valid <= 1'b0;
        end else begin
            ctrl_s1              <= ctrl_dec;
            ctrl_s2              <= ctrl_s1;
            control_out          <= ctrl_s2;
            valid_s1             <= valid_dec;
            valid_s2             <= valid_s1;
            descriptor_out.valid <= valid_s2;
        end
    end

    // Handshake levels are exclusive at the host
    ready_done_excl: assert property (@(posedge ap_clk) disable iff (areset_control)
        !(control_out.ap_ready && control_out.ap_done))
        else $error("ap_ready and ap_done high together");

endmodule

// File: verilog/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter import glay_pkg::*; (
    input  logic                 ap_clk,
    input  logic                 areset_control,
    input  mem_request           req [NUM_PEERS],
    output logic [NUM_PEERS-1:0] grant,
    output logic [NUM_PEERS-1:0] rvalid,
    output mem_request           mem_req
);

    logic [PEER_IDX_W-1:0] last_grant;
    logic [PEER_IDX_W-1:0] winner;
    logic [NUM_PEERS-1:0]  req_valid;
    logic [NUM_PEERS-1:0]  above_last;
    logic [NUM_PEERS-1:0]  masked;

    // Requesters above the last winner go first
    always_comb begin
        for (int p = 0; p < NUM_PEERS; p++) begin
            req_valid[p]  = req[p].valid;
            above_last[p] = (p > int'(last_grant));
        end
    end

    assign masked = req_valid & above_last;

    // Lowest set bit, wrapping to all requests when none is above
    assign grant = (masked != '0) ? (masked & (~masked + NUM_PEERS'(1)))
                                  : (req_valid & (~req_valid + NUM_PEERS'(1)));

    // Index of the granted peer
    always_comb begin
        winner = '0;
        for (int p = 0; p < NUM_PEERS; p++) begin
            if (grant[p]) winner = PEER_IDX_W'(p);
        end
    end

    // Winner goes straight to the RAM
    assign mem_req = (grant != '0) ? req[winner] : '0;

    always_ff @(posedge ap_clk) begin
        if (areset_control) begin
            // Host first after reset
            last_grant <= PEER_IDX_W'(NUM_PEERS - 1);
            rvalid     <= '0;
        end else begin
            if (|grant) last_grant <= winner;
            // Read data lands one cycle after the grant
            for (int p = 0; p < NUM_PEERS; p++) begin
                rvalid[p] <= grant[p] && !req[p].write;
            end
        end
    end

    grant_onehot: assert property (@(posedge ap_clk) disable iff (areset_control)
        $onehot0(grant))
        else $error("more than one grant");

endmodule

// File: verilog/scratch_memory.sv
`timescale 1ns/1ps

module scratch_memory import glay_pkg::*; (
    input  logic        ap_clk,
    input  mem_request  mem_req,
    output logic [31:0] rdata
);

    // --------------------------------------------------
    // Storage
    // --------------------------------------------------
    logic [31:0] mem [MEM_DEPTH];

    // Single port, write or registered read
    always_ff @(posedge ap_clk) begin
        if (mem_req.valid) begin
            if (mem_req.write) begin
                mem[mem_req.addr] <= mem_req.data;
            end else begin
                // Data valid the next cycle
                rdata <= mem[mem_req.addr];
            end
        end
    end

endmodule
